// File: logic/adc_pkg.sv
package adc_pkg;

	// Raw ADC sample width, two's complement
	localparam int adc_width = 16;

	// Field, forward and reflected power
	localparam int num_channels = 3;

	// One sample of every channel, all taken on the same clock
	typedef struct packed {
		logic signed [adc_width-1:0] field;
		logic signed [adc_width-1:0] forward;
		logic signed [adc_width-1:0] reflect;
	} adc_sample_t;

	// Window extremes of one channel
	// Min sits in the upper half so it reads out first
	typedef struct packed {
		logic signed [adc_width-1:0] min;
		logic signed [adc_width-1:0] max;
	} extreme_t;

	// Extremes of all channels, same order as adc_sample_t
	typedef struct packed {
		extreme_t field;
		extreme_t forward;
		extreme_t reflect;
	} extremes_t;

	// Level event thresholds, compared strictly
	localparam logic signed [adc_width-1:0] level_high = 16'sd12000;
	localparam logic signed [adc_width-1:0] level_low = -16'sd12000;

	// Converter rails, a sample sitting on either one counts as saturated
	localparam logic signed [adc_width-1:0] full_scale_pos = 16'sh7fff;
	localparam logic signed [adc_width-1:0] full_scale_neg = 16'sh8000;

endpackage

// File: logic/readout_pkg.sv
package readout_pkg;

	// Slow chain moves one byte per shift strobe
	localparam int byte_width = 8;

	// Sticky level status word
	localparam int status_width = 16;

	// Host supplied tag, used for causality checks on the host side
	localparam int tag_width = 8;

	// Free running cycle timestamp
	localparam int ts_width = 64;

	// Chain length in bytes, frame first and timestamp after it
	localparam int frame_bytes = 16;
	localparam int ts_bytes = 8;

	// Status bit map, one bit per channel in each group
	// Order inside a group is field, forward, reflect
	localparam int st_over = 0;
	localparam int st_under = 3;
	localparam int st_sat = 6;
	// Bits from here up are unused and read as zero
	localparam int st_used = 9;

	// Frame contents, most significant first
	typedef struct packed {
		adc_pkg::extremes_t extremes;
		logic [status_width-1:0] status;
		logic [tag_width-1:0] tag_now;
		logic [tag_width-1:0] tag_old;
	} frame_fields_t;

	// Same 128 bits seen as bytes
	// Byte 0 is the most significant and leaves the chain first
	typedef union packed {
		frame_fields_t fields;
		logic [0:frame_bytes-1][byte_width-1:0] bytes;
	} frame_u;

endpackage

// File: logic/adc_minmax.sv
`timescale 1ns/100ps

module adc_minmax (
	input logic clk,
	input logic rst_n,
	// Window restart
	input logic slow_snap,
	input adc_pkg::adc_sample_t adc_in,
	output adc_pkg::adc_sample_t sample_q,
	output adc_pkg::extremes_t extremes
);

	// Registered samples split per channel so one loop covers all three
	logic signed [adc_pkg::adc_width-1:0] chan [adc_pkg::num_channels];
	adc_pkg::extreme_t ext_arr [adc_pkg::num_channels];

	// Input register, first edge of the pipeline
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_q <= '0;
		end else begin
			sample_q <= adc_in;
		end
	end

	// Channel order matches the struct order
	assign chan[0] = sample_q.field;
	assign chan[1] = sample_q.forward;
	assign chan[2] = sample_q.reflect;

	for (genvar i = 0; i < adc_pkg::num_channels; i++) begin : g_chan
		adc_pkg::extreme_t ext_q;

		// Running min and max, second edge of the pipeline
		// A snap opens a new window from the sample present at that edge
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				ext_q <= '0;
			end else if (slow_snap) begin
				ext_q.min <= chan[i];
				ext_q.max <= chan[i];
			end else begin
				if (chan[i] < ext_q.min) begin
					ext_q.min <= chan[i];
				end
				if (chan[i] > ext_q.max) begin
					ext_q.max <= chan[i];
				end
			end
		end

		assign ext_arr[i] = ext_q;

		// Both bounds start at zero after reset and from one sample after a snap,
		// so they can never cross
		a_min_le_max: assert property (
			@(posedge clk) disable iff (!rst_n)
			ext_q.min <= ext_q.max
		);
	end

	// Back to named fields for the readout side
	assign extremes.field = ext_arr[0];
	assign extremes.forward = ext_arr[1];
	assign extremes.reflect = ext_arr[2];

endmodule

// File: logic/level_monitor.sv
`timescale 1ns/100ps

module level_monitor (
	input logic clk,
	input logic rst_n,
	// Window restart
	input logic slow_snap,
	input adc_pkg::adc_sample_t sample_q,
	output logic [readout_pkg::status_width-1:0] status
);

	logic signed [adc_pkg::adc_width-1:0] chan [adc_pkg::num_channels];
	logic [adc_pkg::num_channels-1:0] over;
	logic [adc_pkg::num_channels-1:0] under;
	logic [adc_pkg::num_channels-1:0] sat;
	// Events of the current sample, laid out as the status word
	logic [readout_pkg::status_width-1:0] events;

	assign chan[0] = sample_q.field;
	assign chan[1] = sample_q.forward;
	assign chan[2] = sample_q.reflect;

	// Level compares, all signed
	// A rail sample also counts as over or under
	always_comb begin
		for (int i = 0; i < adc_pkg::num_channels; i++) begin
			over[i] = chan[i] > adc_pkg::level_high;
			under[i] = chan[i] < adc_pkg::level_low;
			sat[i] = (chan[i] == adc_pkg::full_scale_pos) ||
				(chan[i] == adc_pkg::full_scale_neg);
		end
	end

	// Pack the groups, upper bits stay clear
	always_comb begin
		events = '0;
		events[readout_pkg::st_over +: adc_pkg::num_channels] = over;
		events[readout_pkg::st_under +: adc_pkg::num_channels] = under;
		events[readout_pkg::st_sat +: adc_pkg::num_channels] = sat;
	end

	// Sticky accumulate over the window
	// On a snap the old bits drop and only this cycle's events remain
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			status <= '0;
		end else if (slow_snap) begin
			status <= events;
		end else begin
			status <= status | events;
		end
	end

	// Unused status bits never latch anything
	a_status_upper_zero: assert property (
		@(posedge clk) disable iff (!rst_n)
		status[readout_pkg::status_width-1:readout_pkg::st_used] == '0
	);

endmodule

// File: logic/slow_readout.sv
`timescale 1ns/100ps

module slow_readout (
	input logic clk,
	input logic rst_n,
	// Chain enable, loads with slow_snap and shifts without it
	input logic slow_op,
	input logic slow_snap,
	input logic [readout_pkg::tag_width-1:0] tag,
	input adc_pkg::extremes_t extremes,
	input logic [readout_pkg::status_width-1:0] status,
	output logic [readout_pkg::byte_width-1:0] slow_out
);

	// Free running cycle counter
	logic [readout_pkg::ts_width-1:0] ts_count;

	// Chain registers, frame on top with the timestamp behind it
	readout_pkg::frame_u frame_q;
	logic [0:readout_pkg::ts_bytes-1][readout_pkg::byte_width-1:0] ts_q;

	// Tag seen at the last snap, marks the start of the current window
	logic [readout_pkg::tag_width-1:0] tag_old_q;

	// Frame as it will be captured on a snap
	readout_pkg::frame_u frame_d;

	logic load;
	logic shift;

	assign load = slow_op && slow_snap;
	assign shift = slow_op && !slow_snap;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ts_count <= '0;
		end else begin
			ts_count <= ts_count + 1'b1;
		end
	end

	// Extremes and status still hold the closing window at the snap edge
	always_comb begin
		frame_d.fields.extremes = extremes;
		frame_d.fields.status = status;
		frame_d.fields.tag_now = tag;
		frame_d.fields.tag_old = tag_old_q;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tag_old_q <= '0;
		end else if (load) begin
			tag_old_q <= tag;
		end
	end

	// Byte serial chain
	// Shift moves everything up one byte, timestamp top byte joins the frame tail
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_q <= '0;
			ts_q <= '0;
		end else if (load) begin
			frame_q <= frame_d;
			ts_q <= ts_count;
		end else if (shift) begin
			frame_q.bytes <= {frame_q.bytes[1:readout_pkg::frame_bytes-1], ts_q[0]};
			// Zeros fill in once the timestamp has drained
			ts_q <= {ts_q[1:readout_pkg::ts_bytes-1], {readout_pkg::byte_width{1'b0}}};
		end
	end

	// Head of the chain
	assign slow_out = frame_q.bytes[0];

	// Timestamp differences only mean cycle counts if no edge is ever skipped
	// The edge that leaves reset has no earlier count to step from
	a_count_step: assert property (
		@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> ts_count == $past(ts_count) + 1'b1
	);

endmodule

// File: logic/adc_monitor_shell.sv
`timescale 1ns/100ps

module adc_monitor_shell (
	input logic clk,
	input logic rst_n,
	// Field, forward and reflected ADC samples
	input adc_pkg::adc_sample_t adc_in,
	// Host tag, captured into the frame at each snap
	input logic [readout_pkg::tag_width-1:0] tag,
	// Slow readout strobes, sampled every clock
	input logic slow_op,
	input logic slow_snap,
	output logic [readout_pkg::byte_width-1:0] slow_out
);

	// Registered samples toward the level monitor
	adc_pkg::adc_sample_t sample_q;
	// Window extremes and sticky status toward the readout chain
	adc_pkg::extremes_t extremes;
	logic [readout_pkg::status_width-1:0] status;

	// Input register and windowed min and max
	adc_minmax u_adc_minmax (
		.clk(clk),
		.rst_n(rst_n),
		.slow_snap(slow_snap),
		.adc_in(adc_in),
		.sample_q(sample_q),
		.extremes(extremes)
	);

	// Level events, sticky over the same window
	level_monitor u_level_monitor (
		.clk(clk),
		.rst_n(rst_n),
		.slow_snap(slow_snap),
		.sample_q(sample_q),
		.status(status)
	);

	// Snapshot, timestamp and byte chain
	// Runs only while slow_op is high
	slow_readout u_slow_readout (
		.clk(clk),
		.rst_n(rst_n),
		.slow_op(slow_op),
		.slow_snap(slow_snap),
		.tag(tag),
		.extremes(extremes),
		.status(status),
		.slow_out(slow_out)
	);

endmodule

// File: test/adc_monitor_shell_tb.sv
`timescale 1ns/100ps

module adc_monitor_shell_tb;

	localparam int num_rows = 12;
	// Frame plus timestamp, one more byte past the end is checked as zero
	localparam int chain_bytes = readout_pkg::frame_bytes + readout_pkg::ts_bytes;

	// One stimulus row, filler rows take a random sample instead
	typedef struct packed {
		adc_pkg::adc_sample_t sample;
		logic [7:0] tag;
		logic [7:0] hold;
		logic readout;
		logic filler;
	} row_t;

	logic clk;
	logic rst_n;
	adc_pkg::adc_sample_t adc_in;
	logic [7:0] tag;
	logic slow_op;
	logic slow_snap;
	logic [7:0] slow_out;

	row_t rows [num_rows];
	int seed;
	int errors;
	int checks;
	int edge_count = 0;
	int cycle_limit = 0;
	int release_edge;
	int snap_edge;
	int prev_snap_edge;
	int readouts_done;
	logic [63:0] prev_ts;

	// Reference window, min and max plus sticky events
	adc_pkg::extremes_t model_ext;
	logic [15:0] model_status;
	// Tag from the previous snap
	logic [7:0] model_tag_old;

	adc_monitor_shell u_adc_monitor_shell (
		.clk(clk),
		.rst_n(rst_n),
		.adc_in(adc_in),
		.tag(tag),
		.slow_op(slow_op),
		.slow_snap(slow_snap),
		.slow_out(slow_out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Edge counter, also the watchdog
	always @(posedge clk) begin
		edge_count <= edge_count + 1;
		if (cycle_limit > 0 && edge_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the test sequence did not complete", edge_count);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic row_t make_row(input int f, input int fw, input int r, input int t,
			input int hold, input bit rd, input bit fill);
		row_t row;
		row.sample.field = f[15:0];
		row.sample.forward = fw[15:0];
		row.sample.reflect = r[15:0];
		row.tag = t[7:0];
		row.hold = hold[7:0];
		row.readout = rd;
		row.filler = fill;
		return row;
	endfunction

	// Event bits of one sample
	// Over in 0..2, under in 3..5, rails in 6..8
	function automatic logic [15:0] level_events(input adc_pkg::adc_sample_t s);
		logic [15:0] ev;
		logic signed [15:0] ch [3];
		ch[0] = s.field;
		ch[1] = s.forward;
		ch[2] = s.reflect;
		ev = '0;
		for (int i = 0; i < 3; i++) begin
			ev[i] = ch[i] > adc_pkg::level_high;
			ev[3 + i] = ch[i] < adc_pkg::level_low;
			ev[6 + i] = (ch[i] == 16'sh7fff) || (ch[i] == 16'sh8000);
		end
		return ev;
	endfunction

	function automatic adc_pkg::extreme_t widen(input adc_pkg::extreme_t e,
			input logic signed [15:0] v);
		adc_pkg::extreme_t w;
		w = e;
		if (v < e.min) begin
			w.min = v;
		end
		if (v > e.max) begin
			w.max = v;
		end
		return w;
	endfunction

	task automatic apply_sample(input adc_pkg::adc_sample_t s);
		model_ext.field = widen(model_ext.field, s.field);
		model_ext.forward = widen(model_ext.forward, s.forward);
		model_ext.reflect = widen(model_ext.reflect, s.reflect);
		model_status = model_status | level_events(s);
	endtask

	// A snap restarts the window from the sample held at that edge
	task automatic open_window(input adc_pkg::adc_sample_t s);
		model_ext.field.min = s.field;
		model_ext.field.max = s.field;
		model_ext.forward.min = s.forward;
		model_ext.forward.max = s.forward;
		model_ext.reflect.min = s.reflect;
		model_ext.reflect.max = s.reflect;
		model_status = level_events(s);
	endtask

	// Random quiet sample, strictly inside both limits
	task automatic make_filler(output adc_pkg::adc_sample_t s);
		int f;
		int fw;
		int r;
		f = $random(seed) % 12000;
		fw = $random(seed) % 12000;
		r = $random(seed) % 12000;
		s.field = f[15:0];
		s.forward = fw[15:0];
		s.reflect = r[15:0];
	endtask

	task automatic check_byte(input int n, input logic [7:0] exp);
		checks++;
		assert (slow_out === exp) else begin
			$display("FAIL %0t slow_out byte %0d got %02h expected %02h",
				$time, n, slow_out, exp);
			errors++;
		end
	endtask

	task automatic check_idle();
		checks++;
		assert (slow_out === 8'h00) else begin
			$display("FAIL %0t slow_out before first snap got %02h expected 00", $time, slow_out);
			errors++;
		end
	endtask

	// Snap edge, then 24 shifts, 25 bytes compared
	task automatic run_readout(input logic [7:0] snap_tag);
		readout_pkg::frame_u exp_frame;
		logic [63:0] exp_ts;
		logic [63:0] got_ts;
		logic [7:0] exp_byte;
		exp_frame.fields.extremes = model_ext;
		exp_frame.fields.status = model_status;
		exp_frame.fields.tag_now = snap_tag;
		exp_frame.fields.tag_old = model_tag_old;
		slow_op = 1'b1;
		slow_snap = 1'b1;
		snap_edge = edge_count;
		// Counter starts at zero in the cycle after release
		exp_ts = 64'(snap_edge - release_edge);
		got_ts = '0;
		for (int n = 0; n <= chain_bytes; n++) begin
			@(negedge clk);
			if (n < readout_pkg::frame_bytes) begin
				exp_byte = exp_frame.bytes[n];
			end else if (n < chain_bytes) begin
				exp_byte = exp_ts[8 * (chain_bytes - 1 - n) +: 8];
				got_ts = {got_ts[55:0], slow_out};
			end else begin
				exp_byte = 8'h00;
			end
			check_byte(n, exp_byte);
			if (n < chain_bytes) begin
				slow_snap = 1'b0;
			end else begin
				slow_op = 1'b0;
				slow_snap = 1'b0;
			end
		end
		// Counted edges between snaps against the captured stamps
		if (readouts_done > 0) begin
			checks++;
			assert (got_ts - prev_ts == 64'(snap_edge - prev_snap_edge)) else begin
				$display("FAIL %0t timestamp delta got %0d expected %0d",
					$time, got_ts - prev_ts, snap_edge - prev_snap_edge);
				errors++;
			end
		end
		prev_ts = got_ts;
		prev_snap_edge = snap_edge;
		readouts_done++;
		open_window(adc_in);
		model_tag_old = snap_tag;
	endtask

	task automatic load_table();
		// Mixed window with one field over event
		rows[0] = make_row(1000, -2500, 300, 'h11, 4, 0, 0);
		rows[1] = make_row(0, 0, 0, 'h11, 3, 0, 1);
		rows[2] = make_row(12500, -9000, 8000, 'h11, 3, 0, 0);
		rows[3] = make_row(-700, 4000, -11000, 'h21, 5, 1, 0);
		// Under limit and both rails, quiet row at the end
		rows[4] = make_row(0, 0, 0, 'h21, 3, 0, 1);
		rows[5] = make_row(-12001, 11999, -12000, 'h22, 4, 0, 0);
		rows[6] = make_row(32767, -32768, 0, 'h22, 3, 0, 0);
		rows[7] = make_row(50, 60, 70, 'h35, 3, 1, 0);
		// Quiet window, status must clear
		rows[8] = make_row(0, 0, 0, 'h35, 3, 0, 1);
		rows[9] = make_row(0, 0, 0, 'h36, 4, 0, 1);
		rows[10] = make_row(-100, 200, -300, 'h47, 3, 1, 0);
		// Short window right after a readout
		rows[11] = make_row(5, -5, 0, 'h58, 6, 1, 0);
	endtask

	initial begin
		int sum_hold;
		int num_readouts;
		adc_pkg::adc_sample_t s;
		seed = 32'h449;
		errors = 0;
		checks = 0;
		readouts_done = 0;
		rst_n = 1'b0;
		adc_in = '0;
		tag = '0;
		slow_op = 1'b0;
		slow_snap = 1'b0;
		load_table();
		sum_hold = 0;
		num_readouts = 0;
		for (int i = 0; i < num_rows; i++) begin
			sum_hold += int'(rows[i].hold);
			num_readouts += int'(rows[i].readout);
		end
		cycle_limit = 8 + sum_hold + 30 * num_readouts + 50;
		// Registers clear to zero, reset sample counts in the first window
		model_ext = '0;
		model_status = '0;
		model_tag_old = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		release_edge = edge_count;
		check_idle();
		for (int i = 0; i < num_rows; i++) begin
			if (rows[i].filler) begin
				make_filler(s);
			end else begin
				s = rows[i].sample;
			end
			adc_in = s;
			tag = rows[i].tag;
			apply_sample(s);
			for (int c = 0; c < int'(rows[i].hold); c++) begin
				@(negedge clk);
				if (readouts_done == 0) begin
					check_idle();
				end
			end
			if (rows[i].readout) begin
				run_readout(rows[i].tag);
			end
		end
		repeat (2) @(negedge clk);
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: adc_monitor_shell.f
logic/adc_pkg.sv
logic/readout_pkg.sv
logic/adc_minmax.sv
logic/level_monitor.sv
logic/slow_readout.sv
logic/adc_monitor_shell.sv
test/adc_monitor_shell_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ADC monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module adc_monitor_shell_tb \
	-f adc_monitor_shell.f \
	-o adc_monitor_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/adc_monitor_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1
